/* sinewave.f */
design/audioPkg.sv
design/sineSynth.sv
design/sampleFifo.sv
design/i2sTransmitter.sv
design/sinewave.sv
bench/sinewaveTb.sv

/* run.sh */
#!/bin/sh
# Builds the bench with Verilator, runs it and looks for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sinewave.f --top-module sinewaveTb -o simv &&
obj_dir/simv | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run did not succeed"; exit 1; }

/* bench/sinewaveTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sinewaveTb;
   import audioPkg::*;

   localparam int  frameCycles = 1024;   // 64 bit clocks of 16 cycles each
   localparam int  runFrames   = 60;
   localparam int  cycleLimit  = runFrames * frameCycles * 5 / 4;
   localparam real pi          = 3.14159265358979;

   logic                   CLOCK_50;
   logic                   rstN;
   logic                   audBclk    = 1'b0;
   logic                   audDacLrck = 1'b0;
   logic [tuneWidth-1:0]   sw;
   logic                   muteN;
   logic                   audDacDat;
   logic [9:0]             ledr;

   logic [9:0]             codecCnt   = '0;
   logic [31:0]            lfsr       = 32'hbadabeb3;
   int                     cycle      = 0;
   int                     frameCount = 0;
   int                     seenCount  = 0;
   int                     activeTest = 2;
   int                     errCount [1:5] = '{default: 0};
   int                     sineChecks = 0;
   int                     muteChecks = 0;
   int                     pairChecks = 0;
   logic                   sawFull    = 1'b0;
   logic [63:0]            rxShift    = '0;
   logic [sampleWidth-1:0] rxLeft     = '0;
   logic [sampleWidth-1:0] rxRight    = '0;
   logic [sampleWidth-1:0] expWord    = '0;
   logic                   expMuted   = 1'b0;
   logic                   checkOn    = 1'b0;
   logic [phaseWidth-1:0]  refPhase   = '0;   // Phase starts from zero with the first fetched word
   logic [tuneWidth-1:0]   tuneLog [0:127];
   logic                   muteLog [0:127];
   logic                   frameTick;

   assign frameTick = (frameCount != seenCount);   // One cycle after each captured frame

   sinewave dut_i (
      .CLOCK_50   (CLOCK_50),
      .rstN       (rstN),
      .audBclk    (audBclk),
      .audDacLrck (audDacLrck),
      .sw         (sw),
      .muteN      (muteN),
      .audDacDat  (audDacDat),
      .ledr       (ledr)
   );

   function automatic logic [31:0] nextLfsr(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
   endfunction

   task automatic drawTune(output logic [tuneWidth-1:0] value);
      for (int i = 0; i < tuneWidth; i++)
      begin
         lfsr     = nextLfsr(lfsr);
         value[i] = lfsr[0];
      end
   endtask

   // Full-period sine at the centre of the point picked by the top phase bits
   function automatic logic [sampleWidth-1:0] sineAt(input logic [phaseWidth-1:0] phase);
      int  point;
      real level;
      real mag;
      int  rounded;
      point   = int'(phase[phaseWidth-1 -: 8]);
      level   = 32767.0 * $sin(2.0 * pi * (point + 0.5) / 256.0);
      mag     = (level < 0.0) ? -level : level;
      rounded = $rtoi(mag + 0.5);
      return (level < 0.0) ? sampleWidth'(-rounded) : sampleWidth'(rounded);
   endfunction

   task automatic waitMidFrame(input int target);
      @(posedge CLOCK_50);
      while (frameCount < target || codecCnt != 10'd600)
         @(posedge CLOCK_50);
   endtask

   task automatic reportTest(input int num, input string name);
      $display("Test %0d %s: %s with %0d errors", num, name,
               (errCount[num] == 0) ? "ok" : "bad", errCount[num]);
   endtask

   initial
   begin
      CLOCK_50 = 1'b0;
      forever #10 CLOCK_50 = ~CLOCK_50;
   end

   always @(posedge CLOCK_50)
   begin
      codecCnt   <= codecCnt + 1'b1;
      audBclk    <= codecCnt[3];   // 320 ns bit clock
      audDacLrck <= codecCnt[9];   // Falls together with the bit clock at each frame start
   end

   always @(posedge CLOCK_50)
   begin
      cycle     <= cycle + 1;
      seenCount <= frameCount;
      if (rstN && ledr[3:0] == 4'(fifoDepth))
         sawFull <= 1'b1;
      if (cycle >= cycleLimit)
      begin
         $display("Timeout: the run went past %0d cycles without reaching its end", cycleLimit);
         $display("Result: FAILED");
         $finish;
      end
   end

   always @(posedge audBclk)
      rxShift <= {rxShift[62:0], audDacDat};

   // Each frame edge closes the previous frame
   // Left bits sit on rises 2 to 17 and right bits on rises 34 to 49
   always @(negedge audDacLrck)
   begin : frameCapture
      int   n;
      int   sampleNo;
      logic muted;
      n          = frameCount + 1;
      frameCount <= n;
      tuneLog[n] = sw;      // What the synthesizer sees when this frame's fetch frees a slot
      muteLog[n] = muteN;
      rxLeft     <= rxShift[62:47];
      rxRight    <= rxShift[30:15];
      checkOn    <= (n >= 2);
      if (n >= 2)
      begin
         sampleNo = n - 2;
         // Eight words wait in the FIFO and one more in the synthesizer
         muted    = !muteLog[(sampleNo > 8) ? sampleNo - 8 : 1];
         expMuted <= muted;
         expWord  <= muted ? '0 : sineAt(refPhase);
         refPhase <= refPhase + phaseWidth'(tuneLog[(sampleNo > 7) ? sampleNo - 7 : 1]);
         if (muted)
            muteChecks++;
         else
            sineChecks++;
         pairChecks++;
      end
   end

   resetQuiet: assert property (@(posedge CLOCK_50) cycle >= 2 && !rstN |->
      ledr == '0 && !audDacDat)
   else
   begin
      errCount[1]++;
      $display("Error: ledr %h audDacDat %h in reset, expected 0", ledr, audDacDat);
   end

   idleBeforeFrame: assert property (@(posedge CLOCK_50) rstN && frameCount == 0 |->
      !audDacDat && ledr[9:4] == '0)
   else
   begin
      errCount[1]++;
      $display("Error: audDacDat %h ledr[9:4] %h before the first frame", audDacDat,
               ledr[9:4]);
   end

   sineMatch: assert property (@(posedge CLOCK_50) frameTick && checkOn && !expMuted |->
      rxLeft == expWord)
   else
   begin
      errCount[activeTest]++;
      $display("Error: rxLeft %h expected %h in frame %0d", rxLeft, expWord, frameCount);
   end

   rightMatch: assert property (@(posedge CLOCK_50) frameTick && checkOn |-> rxRight == rxLeft)
   else
   begin
      errCount[3]++;
      $display("Error: rxRight %h expected %h", rxRight, rxLeft);
   end

   muteSilent: assert property (@(posedge CLOCK_50) frameTick && checkOn && expMuted |->
      rxLeft == '0 && rxRight == '0)
   else
   begin
      errCount[4]++;
      $display("Error: rxLeft %h rxRight %h expected 0000 while muted", rxLeft, rxRight);
   end

   fillBound: assert property (@(posedge CLOCK_50) rstN |-> ledr[3:0] <= 4'(fifoDepth))
   else
   begin
      errCount[5]++;
      $display("Error: ledr[3:0] %h exceeds %h", ledr[3:0], fifoDepth);
   end

   noUnderrun: assert property (@(posedge CLOCK_50) rstN |-> !ledr[9])
   else
   begin
      errCount[5]++;
      $display("Error: ledr[9] %h expected 0", ledr[9]);
   end

   initial
   begin : stimulus
      logic [tuneWidth-1:0] nextTune;
      int                   total;
      int                   failedTests;
      rstN  = 1'b0;
      muteN = 1'b1;
      drawTune(sw);
      repeat (10) @(posedge CLOCK_50);
      rstN <= 1'b1;
      waitMidFrame(1);
      reportTest(1, "reset and idle");
      waitMidFrame(10);
      drawTune(nextTune);
      sw <= nextTune;
      waitMidFrame(20);
      drawTune(nextTune);
      sw <= nextTune;
      waitMidFrame(36);
      if (sineChecks == 0)
      begin
         errCount[2]++;
         $display("No left word was compared with the sine model");
      end
      reportTest(2, "sine tracking");
      activeTest = 4;
      muteN <= 1'b0;
      waitMidFrame(44);
      muteN <= 1'b1;
      waitMidFrame(runFrames);
      repeat (4) @(posedge CLOCK_50);
      if (pairChecks == 0)
      begin
         errCount[3]++;
         $display("No frame was received to compare its two words");
      end
      if (muteChecks == 0)
      begin
         errCount[4]++;
         $display("No muted frame was received");
      end
      if (!sawFull)
      begin
         errCount[5]++;
         $display("The FIFO fill count never reached %0d", fifoDepth);
      end
      reportTest(3, "right equals left");
      reportTest(4, "mute and release");
      reportTest(5, "fill and underrun");
      total       = 0;
      failedTests = 0;
      for (int i = 1; i <= 5; i++)
      begin
         total += errCount[i];
         if (errCount[i] != 0)
            failedTests++;
      end
      $display("Tests run 5, tests bad %0d, errors %0d, frames %0d", failedTests, total,
               frameCount);
      if (total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* design/sinewave.sv */
`timescale 1ns/1ps
`default_nettype none

module sinewave
(
   input  logic                           CLOCK_50,
   input  logic                           rstN,
   input  logic                           audBclk,
   input  logic                           audDacLrck,
   input  logic [audioPkg::tuneWidth-1:0] sw,
   input  logic                           muteN,
   output logic                           audDacDat,
   output logic [9:0]                     ledr
);
   import audioPkg::*;

   logic                      wrCyc;
   logic                      wrStb;
   logic [sampleWidth-1:0]    wrDat;
   logic                      wrAck;
   logic                      rdCyc;
   logic                      rdStb;
   logic [sampleWidth-1:0]    rdDat;
   logic                      rdAck;
   logic [fifoCountWidth-1:0] fill;
   logic                      underrun;

   assign ledr = {underrun, 5'b0, fill};   // Fill level on the low LEDs

   sineSynth synth_i (
      .CLOCK_50 (CLOCK_50),
      .rstN     (rstN),
      .tune     (sw),
      .muteN    (muteN),
      .wrCyc    (wrCyc),
      .wrStb    (wrStb),
      .wrDat    (wrDat),
      .wrAck    (wrAck)
   );

   sampleFifo fifo_i (
      .CLOCK_50 (CLOCK_50),
      .rstN     (rstN),
      .wrCyc    (wrCyc),
      .wrStb    (wrStb),
      .wrDat    (wrDat),
      .wrAck    (wrAck),
      .rdCyc    (rdCyc),
      .rdStb    (rdStb),
      .rdDat    (rdDat),
      .rdAck    (rdAck),
      .fill     (fill)
   );

   i2sTransmitter tx_i (
      .CLOCK_50   (CLOCK_50),
      .rstN       (rstN),
      .audBclk    (audBclk),
      .audDacLrck (audDacLrck),
      .rdCyc      (rdCyc),
      .rdStb      (rdStb),
      .rdDat      (rdDat),
      .rdAck      (rdAck),
      .audDacDat  (audDacDat),
      .underrun   (underrun)
   );

endmodule

`default_nettype wire

/* design/i2sTransmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2sTransmitter
(
   input  logic                             CLOCK_50,
   input  logic                             rstN,
   input  logic                             audBclk,
   input  logic                             audDacLrck,
   output logic                             rdCyc,
   output logic                             rdStb,
   input  logic [audioPkg::sampleWidth-1:0] rdDat,
   input  logic                             rdAck,
   output logic                             audDacDat,
   output logic                             underrun
);
   import audioPkg::*;

   logic [2:0]             bclkPipe;
   logic [2:0]             lrPipe;
   logic                   bclkFall;
   logic                   lrFall;
   logic [sampleWidth-1:0] sample;
   logic [5:0]             bitCount;   // Falling edges since the frame started
   txState                 state;

   assign bclkFall = bclkPipe[2] && !bclkPipe[1];
   assign lrFall   = lrPipe[2] && !lrPipe[1];   // Left word begins

   always_ff @(posedge CLOCK_50 or negedge rstN)
   begin
      if (!rstN)
      begin
         bclkPipe <= '0;
         lrPipe   <= '0;
      end
      else
      begin
         bclkPipe <= {bclkPipe[1:0], audBclk};  // Two sync stages plus an edge stage
         lrPipe   <= {lrPipe[1:0], audDacLrck};
      end
   end

   always_ff @(posedge CLOCK_50 or negedge rstN)
   begin
      if (!rstN)
      begin
         state     <= txIdle;
         rdCyc     <= 1'b0;
         rdStb     <= 1'b0;
         audDacDat <= 1'b0;
         underrun  <= 1'b0;
         bitCount  <= '0;
      end
      else
      begin
         case (state)
            txIdle:
               if (lrFall)
               begin
                  rdCyc <= 1'b1;
                  rdStb <= 1'b1;
                  state <= txFetch;
               end
            txFetch:
               if (rdAck)
               begin
                  rdCyc <= 1'b0;
                  rdStb <= 1'b0;
                  state <= txDelay;
               end
               else if (bclkFall)
               begin
                  rdCyc     <= 1'b0;   // No sample in time so this frame goes out silent
                  rdStb     <= 1'b0;
                  underrun  <= 1'b1;
                  audDacDat <= 1'b0;
                  bitCount  <= 6'd1;
                  state     <= txShift;
               end
            txDelay:
               if (bclkFall)
               begin
                  audDacDat <= sample[sampleWidth-1];
                  bitCount  <= 6'd1;
                  state     <= txShift;
               end
            txShift:
               if (lrFall)
               begin
                  rdCyc    <= 1'b1;
                  rdStb    <= 1'b1;
                  bitCount <= '0;
                  state    <= txFetch;
               end
               else if (bclkFall)
               begin
                  // The first 16 slots of each half-frame carry the word and the rest are zero
                  audDacDat <= bitCount[4] ? 1'b0 : sample[~bitCount[3:0]];
                  bitCount  <= bitCount + 6'd1;
                  if (bitCount == 6'd63)
                     state <= txIdle;
               end
            default:
               state <= txIdle;
         endcase
      end
   end

   always_ff @(posedge CLOCK_50)
   begin
      if (state == txFetch && rdAck)
         sample <= rdDat;   // Same word serves left and right
      else if (state == txFetch && bclkFall)
         sample <= '0;
   end

   assert property (@(posedge CLOCK_50) disable iff (!rstN)
      !$stable(audDacDat) |-> $past(bclkFall));

endmodule

`default_nettype wire

/* design/sampleFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleFifo
(
   input  logic                                CLOCK_50,
   input  logic                                rstN,
   input  logic                                wrCyc,
   input  logic                                wrStb,
   input  logic [audioPkg::sampleWidth-1:0]    wrDat,
   output logic                                wrAck,
   input  logic                                rdCyc,
   input  logic                                rdStb,
   output logic [audioPkg::sampleWidth-1:0]    rdDat,
   output logic                                rdAck,
   output logic [audioPkg::fifoCountWidth-1:0] fill
);
   import audioPkg::*;

   logic [sampleWidth-1:0]    mem [fifoDepth];
   logic [fifoCountWidth-2:0] wrPtr;
   logic [fifoCountWidth-2:0] rdPtr;
   logic                      full;
   logic                      empty;
   logic                      doWrite;
   logic                      doRead;

   assign full    = (fill == fifoCountWidth'(fifoDepth));
   assign empty   = (fill == '0);
   assign doWrite = wrCyc && wrStb && !wrAck && !full;  // Ack cycle is not a new request
   assign doRead  = rdCyc && rdStb && !rdAck && !empty;

   always_ff @(posedge CLOCK_50 or negedge rstN)
   begin
      if (!rstN)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         fill  <= '0;
         wrAck <= 1'b0;
         rdAck <= 1'b0;
      end
      else
      begin
         wrAck <= doWrite;
         rdAck <= doRead;
         if (doWrite)
            wrPtr <= wrPtr + 1'b1;
         if (doRead)
            rdPtr <= rdPtr + 1'b1;
         case ({doWrite, doRead})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;   // Both or neither leave the count alone
         endcase
      end
   end

   always_ff @(posedge CLOCK_50)
   begin
      if (doWrite)
         mem[wrPtr] <= wrDat;
      if (doRead)
         rdDat <= mem[rdPtr];
   end

   assert property (@(posedge CLOCK_50) disable iff (!rstN)
      fill <= fifoCountWidth'(fifoDepth));

   assert property (@(posedge CLOCK_50) disable iff (!rstN)
      wrAck |-> $past(fill) != fifoCountWidth'(fifoDepth));

   assert property (@(posedge CLOCK_50) disable iff (!rstN)
      rdAck |-> $past(fill) != '0);

endmodule

`default_nettype wire

/* design/sineSynth.sv */
`timescale 1ns/1ps
`default_nettype none

module sineSynth
(
   input  logic                             CLOCK_50,
   input  logic                             rstN,
   input  logic [audioPkg::tuneWidth-1:0]   tune,
   input  logic                             muteN,
   output logic                             wrCyc,
   output logic                             wrStb,
   output logic [audioPkg::sampleWidth-1:0] wrDat,
   input  logic                             wrAck
);
   import audioPkg::*;

   synthState              state;
   logic [phaseWidth-1:0]  phase;
   logic [5:0]             point;
   logic [sampleWidth-2:0] magnitude;
   logic                   negative;
   logic [sampleWidth-1:0] magExt;

   // Second and fourth quarters of the period read the table backwards
   assign point  = phase[phaseWidth-2] ? ~phase[phaseWidth-3 -: 6] : phase[phaseWidth-3 -: 6];
   assign magExt = {1'b0, magnitude};

   always_ff @(posedge CLOCK_50 or negedge rstN)
   begin
      if (!rstN)
      begin
         state <= synthLookup;
         phase <= '0;
         wrCyc <= 1'b0;
         wrStb <= 1'b0;
      end
      else
      begin
         case (state)
            synthLookup:
               state <= synthOffer;
            synthOffer:
            begin
               wrCyc <= 1'b1;
               wrStb <= 1'b1;
               state <= synthWait;
            end
            synthWait:
               if (wrAck)
               begin
                  wrCyc <= 1'b0;
                  wrStb <= 1'b0;
                  phase <= phase + phaseWidth'(tune);  // Advances even while muted
                  state <= synthLookup;
               end
            default:
               state <= synthLookup;
         endcase
      end
   end

   always_ff @(posedge CLOCK_50)
   begin
      if (state == synthLookup)
      begin
         magnitude <= sineQuarter(point);
         negative  <= phase[phaseWidth-1];  // Second half of the period is negative
      end
      if (state == synthOffer)
         wrDat <= muteN ? (negative ? -magExt : magExt) : '0;
   end

   // The offered word must not move until the FIFO has taken it
   assert property (@(posedge CLOCK_50) disable iff (!rstN)
      wrStb && !wrAck |=> wrStb && $stable(wrDat));

endmodule

`default_nettype wire

/* design/audioPkg.sv */
`default_nettype none

package audioPkg;

   localparam int sampleWidth    = 16;  // Two's complement audio sample
   localparam int phaseWidth     = 24;  // Top 8 bits index one sine period
   localparam int tuneWidth      = 10;
   localparam int fifoDepth      = 8;
   localparam int fifoCountWidth = 4;   // Holds every count from empty up to full

   // Magnitudes at the centres of the 64 points of the first quarter wave
   localparam logic [sampleWidth-2:0] quarterTable [64] = '{
      402, 1206, 2009, 2811, 3612, 4410, 5205, 5998,
      6786, 7571, 8351, 9126, 9896, 10659, 11417, 12167,
      12910, 13645, 14372, 15090, 15800, 16499, 17189, 17869,
      18537, 19195, 19841, 20475, 21096, 21705, 22301, 22884,
      23452, 24007, 24547, 25072, 25582, 26077, 26556, 27019,
      27466, 27896, 28310, 28706, 29085, 29447, 29791, 30117,
      30424, 30714, 30985, 31237, 31470, 31685, 31880, 32057,
      32213, 32351, 32469, 32567, 32646, 32705, 32745, 32765
   };

   function automatic logic [sampleWidth-2:0] sineQuarter(input logic [5:0] point);
      return quarterTable[point];
   endfunction

   typedef enum logic [1:0] {
      synthLookup,
      synthOffer,
      synthWait
   } synthState;

   typedef enum logic [1:0] {
      txIdle,
      txFetch,
      txDelay,
      txShift
   } txState;

endpackage

`default_nettype wire
